//--- hw/credit_fifo.sv
`timescale 1ns/1ps

module credit_fifo #(
	parameter int DEPTH = 4
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  push,
	input  ext_bus_pkg::bus_req_t push_data,
	input  logic                  pop,
	output logic                  valid,
	output ext_bus_pkg::bus_req_t data,
	output logic                  credit
);
	import ext_bus_pkg::*;

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	bus_req_t         mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_pop;

	assign valid  = (count != '0);
	assign data   = mem[rd_ptr];
	assign do_pop = pop && valid;

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			credit <= 1'b0;
		end else begin
			credit <= do_pop; // one credit back per entry.
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({push, do_pop})
			2'b10: count <= count + 1'b1;
			2'b01: count <= count - 1'b1;
			default: count <= count;
			endcase
		end
	end

endmodule

//--- hw/ext_bus_pkg.sv
package ext_bus_pkg;

	// *************************************************************************
	// cpu side transfer records
	// *************************************************************************

	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  wdata;
		logic        write;
	} bus_req_t;

	// reads only.
	typedef struct packed {
		logic [7:0] rdata;
	} bus_rsp_t;

	// *************************************************************************
	// cartridge pins
	// *************************************************************************

	typedef struct packed {
		logic [15:0] a;
		logic [7:0]  d;
		logic        d_oe;
		logic        rd_n;
		logic        wr_n;
		logic        cs_n;
	} ext_pins_t;

	typedef enum logic [2:0] {
		REG_ROM,
		REG_EXTRAM,
		REG_OAM,
		REG_DMA,
		REG_NONE
	} region_e;

	localparam int          OAM_BYTES    = 160;
	localparam logic [15:0] DMA_REG_ADDR = 16'hFF46;

	// rom 0000-7fff, cart ram + wram a000-fdff.
	function automatic region_e region_of(input logic [15:0] addr);
		region_e r;
		if (!addr[15])
			r = REG_ROM;
		else if (addr >= 16'hA000 && addr <= 16'hFDFF)
			r = REG_EXTRAM;
		else if (addr >= 16'hFE00 && addr < 16'hFE00 + 16'(OAM_BYTES))
			r = REG_OAM;
		else if (addr == DMA_REG_ADDR)
			r = REG_DMA;
		else
			r = REG_NONE; // 8000-9fff and the rest of fexx/ffxx.
		return r;
	endfunction

endpackage

//--- hw/ext_bus_top.sv
`timescale 1ns/1ps

module ext_bus_top #(
	parameter int REQ_DEPTH   = 4,
	parameter int RSP_CREDITS = 2,
	parameter int BUS_CYCLES  = 2
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   req_valid,
	input  ext_bus_pkg::bus_req_t  req,
	output logic                   req_credit,
	output logic                   rsp_valid,
	output ext_bus_pkg::bus_rsp_t  rsp,
	input  logic                   rsp_credit,
	output ext_bus_pkg::ext_pins_t ext,
	input  logic [7:0]             ext_d_in
);
	import ext_bus_pkg::*;

	bus_req_t    q_req;
	logic        q_valid;
	logic        q_pop;
	logic        dma_start;
	logic [7:0]  dma_page;
	logic [7:0]  page_q;
	logic        dma_active;
	logic [15:0] dma_req_addr;
	logic        dma_byte_valid;
	logic [7:0]  dma_byte;
	logic        oam_rd_en;
	logic [7:0]  oam_rd_idx;
	logic [7:0]  oam_rd_data;
	logic        oam_wr_en;
	logic [7:0]  oam_wr_idx;
	logic [7:0]  oam_wr_data;

	credit_fifo #(
		.DEPTH (REQ_DEPTH)
	) u_req_q (
		.clk       (clk),
		.rst_n     (rst_n),
		.push      (req_valid),
		.push_data (req),
		.pop       (q_pop),
		.valid     (q_valid),
		.data      (q_req),
		.credit    (req_credit)
	);

	ext_cpu_bus #(
		.RSP_CREDITS (RSP_CREDITS),
		.BUS_CYCLES  (BUS_CYCLES)
	) u_bus (
		.clk            (clk),
		.rst_n          (rst_n),
		.q_valid        (q_valid),
		.q_req          (q_req),
		.q_pop          (q_pop),
		.rsp_valid      (rsp_valid),
		.rsp            (rsp),
		.rsp_credit     (rsp_credit),
		.ext            (ext),
		.ext_d_in       (ext_d_in),
		.dma_active     (dma_active),
		.dma_req_addr   (dma_req_addr),
		.dma_byte_valid (dma_byte_valid),
		.dma_byte       (dma_byte),
		.dma_start      (dma_start),
		.dma_page       (dma_page),
		.oam_rd_en      (oam_rd_en),
		.oam_rd_idx     (oam_rd_idx),
		.oam_rd_data    (oam_rd_data),
		.oam_wr_en      (oam_wr_en),
		.oam_wr_idx     (oam_wr_idx),
		.oam_wr_data    (oam_wr_data),
		.page_q         (page_q)
	);

	oam_dma u_dma (
		.clk            (clk),
		.rst_n          (rst_n),
		.dma_start      (dma_start),
		.dma_page       (dma_page),
		.page_q         (page_q),
		.dma_active     (dma_active),
		.dma_req_addr   (dma_req_addr),
		.dma_byte_valid (dma_byte_valid),
		.dma_byte       (dma_byte),
		.oam_rd_en      (oam_rd_en),
		.oam_rd_idx     (oam_rd_idx),
		.oam_rd_data    (oam_rd_data),
		.oam_wr_en      (oam_wr_en),
		.oam_wr_idx     (oam_wr_idx),
		.oam_wr_data    (oam_wr_data)
	);

endmodule

//--- hw/ext_cpu_bus.sv
`timescale 1ns/1ps

module ext_cpu_bus #(
	parameter int RSP_CREDITS = 2,
	parameter int BUS_CYCLES  = 2
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   q_valid,
	input  ext_bus_pkg::bus_req_t  q_req,
	output logic                   q_pop,
	output logic                   rsp_valid,
	output ext_bus_pkg::bus_rsp_t  rsp,
	input  logic                   rsp_credit,
	output ext_bus_pkg::ext_pins_t ext,
	input  logic [7:0]             ext_d_in,
	input  logic                   dma_active,
	input  logic [15:0]            dma_req_addr,
	output logic                   dma_byte_valid,
	output logic [7:0]             dma_byte,
	output logic                   dma_start,
	output logic [7:0]             dma_page,
	output logic                   oam_rd_en,
	output logic [7:0]             oam_rd_idx,
	input  logic [7:0]             oam_rd_data,
	output logic                   oam_wr_en,
	output logic [7:0]             oam_wr_idx,
	output logic [7:0]             oam_wr_data,
	input  logic [7:0]             page_q
);
	import ext_bus_pkg::*;

	localparam int CNT_W = (BUS_CYCLES > 1) ? $clog2(BUS_CYCLES) : 1;
	localparam int CRD_W = $clog2(RSP_CREDITS + 1);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_STROBE,
		ST_RECOVER
	} state_e;

	state_e           state;
	logic [CNT_W-1:0] strobe_cnt;
	logic [CRD_W-1:0] crd_cnt;
	logic             owner_dma;
	logic             cur_read;
	logic             rsp_oam;
	logic [7:0]       rsp_data_q;
	ext_pins_t        pins;

	region_e          q_region;
	logic             q_is_ext;
	logic             q_ok;
	logic             free_slot;
	logic             last_strobe;
	logic             int_pop;
	logic             cpu_launch;
	logic             dma_launch;
	logic             take;
	logic [15:0]      launch_addr;

	// *************************************************************************
	// decode and issue
	// *************************************************************************

	always_comb begin
		q_region    = region_of(q_req.addr);
		q_is_ext    = (q_region == REG_ROM) || (q_region == REG_EXTRAM);
		q_ok        = q_valid && (q_req.write || crd_cnt != '0);
		free_slot   = (state != ST_STROBE);
		last_strobe = (strobe_cnt == CNT_W'(BUS_CYCLES - 1));
		int_pop     = free_slot && q_ok && !q_is_ext;
		dma_start   = int_pop && q_req.write && (q_region == REG_DMA) && !dma_active;
		cpu_launch  = free_slot && q_ok && q_is_ext && !dma_active;
		dma_launch  = free_slot && (dma_active || dma_start);
		take        = (int_pop || cpu_launch) && !q_req.write;
		// dma owns the address pins while it runs.
		if (dma_start)
			launch_addr = {q_req.wdata, 8'h00};
		else if (dma_active)
			launch_addr = dma_req_addr;
		else
			launch_addr = q_req.addr;
	end

	assign q_pop       = int_pop || cpu_launch;
	assign dma_page    = q_req.wdata;
	assign oam_rd_en   = int_pop && (q_region == REG_OAM) && !q_req.write;
	assign oam_rd_idx  = q_req.addr[7:0];
	assign oam_wr_en   = int_pop && (q_region == REG_OAM) && q_req.write;
	assign oam_wr_idx  = q_req.addr[7:0];
	assign oam_wr_data = q_req.wdata;

	// *************************************************************************
	// pin sequencer
	// *************************************************************************

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state      <= ST_IDLE;
			strobe_cnt <= '0;
			owner_dma  <= 1'b0;
			cur_read   <= 1'b0;
			pins       <= '{a: 16'h0000, d: 8'h00, d_oe: 1'b0,
				rd_n: 1'b1, wr_n: 1'b1, cs_n: 1'b1};
		end else begin
			case (state)
			ST_STROBE: begin
				if (last_strobe) begin
					state     <= ST_RECOVER;
					pins.rd_n <= 1'b1;
					pins.wr_n <= 1'b1;
					pins.cs_n <= 1'b1;
					pins.d_oe <= 1'b0;
				end else begin
					strobe_cnt <= strobe_cnt + 1'b1;
				end
			end
			default: begin // idle and recover can both launch.
				state <= ST_IDLE;
				if (cpu_launch || dma_launch) begin
					state      <= ST_STROBE;
					strobe_cnt <= '0;
					owner_dma  <= dma_launch;
					cur_read   <= cpu_launch && !q_req.write;
					pins.a     <= launch_addr;
					pins.rd_n  <= cpu_launch && q_req.write;
					pins.wr_n  <= !(cpu_launch && q_req.write);
					pins.cs_n  <= (region_of(launch_addr) != REG_EXTRAM);
					pins.d_oe  <= cpu_launch && q_req.write;
					if (cpu_launch && q_req.write)
						pins.d <= q_req.wdata;
				end
			end
			endcase
		end
	end

	assign ext            = pins;
	assign dma_byte_valid = (state == ST_STROBE) && last_strobe && owner_dma;
	assign dma_byte       = ext_d_in;

	// *************************************************************************
	// responses
	// *************************************************************************

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rsp_valid <= 1'b0;
			rsp_oam   <= 1'b0;
			crd_cnt   <= CRD_W'(RSP_CREDITS);
		end else begin
			crd_cnt   <= crd_cnt - CRD_W'(take) + CRD_W'(rsp_credit);
			rsp_valid <= 1'b0;
			if (state == ST_STROBE && last_strobe && cur_read) begin
				rsp_valid <= 1'b1;
				rsp_oam   <= 1'b0;
			end else if (int_pop && !q_req.write) begin
				rsp_valid <= 1'b1;
				rsp_oam   <= (q_region == REG_OAM); // ram read lands next cycle.
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == ST_STROBE && last_strobe)
			rsp_data_q <= ext_d_in;
		else if (int_pop)
			rsp_data_q <= (q_region == REG_DMA) ? page_q : 8'hFF;
	end

	assign rsp.rdata = rsp_oam ? oam_rd_data : rsp_data_q;

endmodule

//--- hw/oam_dma.sv
`timescale 1ns/1ps

module oam_dma (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        dma_start,
	input  logic [7:0]  dma_page,
	output logic [7:0]  page_q,
	output logic        dma_active,
	output logic [15:0] dma_req_addr,
	input  logic        dma_byte_valid,
	input  logic [7:0]  dma_byte,
	input  logic        oam_rd_en,
	input  logic [7:0]  oam_rd_idx,
	output logic [7:0]  oam_rd_data,
	input  logic        oam_wr_en,
	input  logic [7:0]  oam_wr_idx,
	input  logic [7:0]  oam_wr_data
);
	import ext_bus_pkg::*;

	logic [7:0] idx;
	logic       rd_blocked;
	logic       ram_we;
	logic [7:0] ram_waddr;
	logic [7:0] ram_wdata;
	logic [7:0] ram_rdata;

	// *************************************************************************
	// copy engine
	// *************************************************************************

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			page_q     <= 8'h00;
			dma_active <= 1'b0;
			idx        <= 8'h00;
		end else if (!dma_active) begin
			if (dma_start) begin
				page_q     <= dma_page;
				dma_active <= 1'b1;
				idx        <= 8'h00;
			end
		end else if (dma_byte_valid) begin
			idx <= idx + 1'b1; // next source byte.
			if (idx == 8'(OAM_BYTES - 1))
				dma_active <= 1'b0;
		end
	end

	assign dma_req_addr = {page_q, idx};

	// *************************************************************************
	// object ram ownership
	// *************************************************************************

	// cpu writes are dropped while a copy runs.
	always_comb begin
		if (dma_active) begin
			ram_we    = dma_byte_valid;
			ram_waddr = idx;
			ram_wdata = dma_byte;
		end else begin
			ram_we    = oam_wr_en;
			ram_waddr = oam_wr_idx;
			ram_wdata = oam_wr_data;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			rd_blocked <= 1'b0;
		else if (oam_rd_en)
			rd_blocked <= dma_active;
	end

	oam_ram u_oam_ram (
		.clk   (clk),
		.we    (ram_we),
		.waddr (ram_waddr),
		.wdata (ram_wdata),
		.raddr (oam_rd_idx),
		.rdata (ram_rdata)
	);

	assign oam_rd_data = rd_blocked ? 8'hFF : ram_rdata;

endmodule

//--- hw/oam_ram.sv
`timescale 1ns/1ps

module oam_ram (
	input  logic       clk,
	input  logic       we,
	input  logic [7:0] waddr,
	input  logic [7:0] wdata,
	input  logic [7:0] raddr,
	output logic [7:0] rdata
);
	import ext_bus_pkg::*;

	logic [7:0] mem [OAM_BYTES];

	// one write port, registered read.
	always_ff @(posedge clk) begin
		if (we)
			mem[waddr] <= wdata;
		rdata <= mem[raddr];
	end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_ext_bus -f sim.f -o tb_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed"
	exit $status
fi

./obj_dir/tb_sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed"
	exit $status
fi

exit 0

//--- sim.f
hw/ext_bus_pkg.sv
hw/credit_fifo.sv
hw/oam_ram.sv
hw/oam_dma.sv
hw/ext_cpu_bus.sv
hw/ext_bus_top.sv
test/ext_mem_model.sv
test/tb_ext_bus.sv

//--- test/ext_mem_model.sv
`timescale 1ns/1ps

module ext_mem_model (
	input  ext_bus_pkg::ext_pins_t pins,
	output logic [7:0]             d_in
);
	logic [7:0]  mem [65536];
	logic [31:0] lfsr_state;
	logic        wr_n;

	// fibonacci lfsr with taps 32 22 2 1.
	function automatic logic step_bit();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	initial begin
		logic [7:0] b;
		lfsr_state = 32'heff2;
		for (int i = 0; i < 65536; i++) begin
			for (int k = 0; k < 8; k++)
				b = {b[6:0], step_bit()};
			mem[i] = b;
		end
	end

	assign wr_n = pins.wr_n;
	assign d_in = !pins.rd_n ? mem[pins.a] : 8'hFF; // bus floats high.

	always @(posedge wr_n) begin
		mem[pins.a] <= pins.d;
	end

endmodule

//--- test/tb_ext_bus.sv
`timescale 1ns/1ps

module tb_ext_bus;
	import ext_bus_pkg::*;

	localparam int REQ_DEPTH   = 4;
	localparam int RSP_CREDITS = 2;
	localparam int BUS_CYCLES  = 2;
	localparam int TIMEOUT     = 2 * (160 * 3 + 200);

	logic       clk;
	logic       rst_n;
	logic       req_valid;
	bus_req_t   req;
	logic       req_credit;
	logic       rsp_valid;
	bus_rsp_t   rsp;
	logic       rsp_credit;
	ext_pins_t  ext;
	logic [7:0] ext_d_in;

	logic [7:0]  shadow [65536];
	logic [31:0] lfsr_state;
	logic [7:0]  rsp_q [$];
	logic [15:0] log_addr [$];
	int          log_cyc [$];
	logic        log_wr [$];
	logic [7:0]  log_d [$];
	int          cyc;
	int          run;
	int          cs_cycles;
	int          rsp_seen;
	int          credits_given;
	int          crd_back;
	int          crd_used;
	logic        hold_credits;

	ext_bus_top UUT (
		.clk        (clk),
		.rst_n      (rst_n),
		.req_valid  (req_valid),
		.req        (req),
		.req_credit (req_credit),
		.rsp_valid  (rsp_valid),
		.rsp        (rsp),
		.rsp_credit (rsp_credit),
		.ext        (ext),
		.ext_d_in   (ext_d_in)
	);

	ext_mem_model u_mem (
		.pins (ext),
		.d_in (ext_d_in)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ************************************************************************
	// helpers
	// ************************************************************************

	task automatic abort(input string msg);
		$display("%s", msg);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input int exp, input int act);
		$display("ERROR %s: expected %0h, got %0h", name, exp, act);
		$display("Some tests failed");
		$fatal(1);
	endtask

	function automatic logic step_bit();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	function automatic logic [15:0] take_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int k = 0; k < n; k++)
			v = {v[14:0], step_bit()};
		return v;
	endfunction

	function automatic logic in_cart_ram(input logic [15:0] a);
		return a >= 16'hA000 && a <= 16'hFDFF;
	endfunction

	task automatic issue(input logic [15:0] addr, input logic [7:0] wdata, input logic write);
		while (REQ_DEPTH + crd_back - crd_used == 0)
			@(negedge clk);
		req_valid = 1'b1;
		req       = '{addr: addr, wdata: wdata, write: write};
		crd_used++;
		@(negedge clk);
		req_valid = 1'b0;
	endtask

	task automatic wait_rsp(input int n);
		while (rsp_q.size() < n)
			@(negedge clk);
	endtask

	task automatic read_check(input string name, input logic [15:0] addr, input logic [7:0] exp);
		logic [7:0] got;
		issue(addr, 8'h00, 1'b0);
		wait_rsp(1);
		got = rsp_q.pop_front();
		assert (got == exp) else report_mismatch(name, exp, got);
	endtask

	// ************************************************************************
	// pin and channel monitors
	// ************************************************************************

	always @(posedge clk) begin
		logic strobe;
		cyc++;
		if (cyc >= TIMEOUT)
			abort("run timed out before the tests finished");
		if (rst_n) begin
			if (rsp_valid) begin
				rsp_q.push_back(rsp.rdata);
				rsp_seen++;
			end
			if (req_credit)
				crd_back++;
			if (!ext.cs_n)
				cs_cycles++;
			strobe = !ext.rd_n || !ext.wr_n;
			assert (strobe ? ext.cs_n == !in_cart_ram(ext.a) : ext.cs_n)
				else abort("cs_n does not follow the strobe and the region");
			assert (ext.d_oe == !ext.wr_n) else abort("d_oe is high outside the write strobe");
			if (strobe) begin
				if (run == 0) begin // strobe start.
					log_addr.push_back(ext.a);
					log_cyc.push_back(cyc);
					log_wr.push_back(!ext.wr_n);
					log_d.push_back(ext.d);
				end
				run++;
			end else if (run != 0) begin
				assert (run == BUS_CYCLES) else report_mismatch("strobe_len", BUS_CYCLES, run);
				run = 0;
			end
		end
	end

	// hands response credits back one per cycle.
	always @(negedge clk) begin
		if (!hold_credits && rsp_seen > credits_given) begin
			rsp_credit = 1'b1;
			credits_given++;
		end else begin
			rsp_credit = 1'b0;
		end
	end

	// ************************************************************************
	// tests
	// ************************************************************************

	task automatic test_reset();
		assert (ext.rd_n && ext.wr_n && ext.cs_n) else abort("strobes not idle after reset");
		assert (!ext.d_oe && !rsp_valid && !req_credit) else abort("outputs active after reset");
		assert (!UUT.dma_active) else abort("dma active after reset");
		assert (ext.a == 16'h0000) else report_mismatch("reset_addr", 0, ext.a);
		assert (REQ_DEPTH + crd_back - crd_used == REQ_DEPTH)
			else report_mismatch("reset_credits", REQ_DEPTH, REQ_DEPTH + crd_back - crd_used);
	endtask

	task automatic test_rom_reads();
		logic [15:0] a;
		int          cs0;
		for (int i = 0; i < 5; i++) begin
			a   = take_bits(15);
			cs0 = cs_cycles;
			log_addr.delete();
			read_check("rom_read", a, shadow[a]);
			assert (log_addr.size() == 1 && log_addr[0] == a) else abort("rom read strobe missing");
			assert (cs_cycles == cs0) else report_mismatch("rom_cs", cs0, cs_cycles);
		end
	endtask

	task automatic test_ext_ram();
		int cs0;
		cs0 = cs_cycles;
		log_addr.delete();
		log_d.delete();
		log_wr.delete();
		issue(16'hC005, 8'h5A, 1'b1);
		while (log_addr.size() == 0)
			@(negedge clk);
		shadow[16'hC005] = 8'h5A;
		assert (log_wr[0] && log_d[0] == 8'h5A) else report_mismatch("ram_wdata", 8'h5A, log_d[0]);
		read_check("ram_readback", 16'hC005, 8'h5A);
		assert (cs_cycles - cs0 == 2 * BUS_CYCLES)
			else report_mismatch("ram_cs", 2 * BUS_CYCLES, cs_cycles - cs0);
	endtask

	task automatic test_unmapped();
		log_addr.delete();
		read_check("unmapped_8xxx", 16'h8ABC, 8'hFF);
		read_check("unmapped_fea0", 16'hFEA0, 8'hFF);
		read_check("unmapped_ff00", 16'hFF00, 8'hFF);
		read_check("unmapped_ffff", 16'hFFFF, 8'hFF);
		issue(16'h9000, 8'h11, 1'b1);
		issue(16'hFF01, 8'h22, 1'b1);
		while (crd_back != crd_used)
			@(negedge clk);
		repeat (BUS_CYCLES + 2) @(negedge clk);
		assert (log_addr.size() == 0) else report_mismatch("unmapped_strobes", 0, log_addr.size());
	endtask

	task automatic test_credit_flow();
		logic [15:0] addrs [4];
		logic [7:0]  got;
		int          base;
		while (crd_back != crd_used)
			@(negedge clk);
		base         = crd_back;
		hold_credits = 1'b1;
		for (int i = 0; i < 4; i++) begin
			addrs[i] = take_bits(15);
			issue(addrs[i], 8'h00, 1'b0);
		end
		wait_rsp(RSP_CREDITS);
		repeat (8 * (BUS_CYCLES + 1)) @(negedge clk);
		assert (rsp_q.size() == RSP_CREDITS) else report_mismatch("held_rsps", RSP_CREDITS, rsp_q.size());
		hold_credits = 1'b0;
		wait_rsp(4);
		for (int i = 0; i < 4; i++) begin
			got = rsp_q.pop_front();
			assert (got == shadow[addrs[i]]) else report_mismatch("credit_order", shadow[addrs[i]], got);
		end
		while (crd_back - base < 4)
			@(negedge clk);
		repeat (3) @(negedge clk);
		assert (crd_back - base == 4) else report_mismatch("req_credits", 4, crd_back - base);
	endtask

	task automatic test_dma();
		logic [7:0]  page;
		logic [15:0] cpu_a;
		logic [7:0]  got;
		page  = 8'hC0;
		cpu_a = 16'h1234;
		log_addr.delete();
		log_cyc.delete();
		issue(16'hFF46, page, 1'b1);
		issue(cpu_a, 8'h00, 1'b0);
		wait_rsp(1);
		got = rsp_q.pop_front();
		assert (got == shadow[cpu_a]) else report_mismatch("dma_cpu_read", shadow[cpu_a], got);
		assert (log_addr.size() == 161) else report_mismatch("dma_strobes", 161, log_addr.size());
		for (int i = 0; i < 160; i++)
			assert (log_addr[i] == {page, 8'(i)}) else report_mismatch("dma_addr", {page, 8'(i)}, log_addr[i]);
		assert (log_addr[160] == cpu_a) else report_mismatch("dma_cpu_addr", cpu_a, log_addr[160]);
		assert (log_cyc[160] - log_cyc[0] == 160 * (BUS_CYCLES + 1))
			else report_mismatch("dma_length", 160 * (BUS_CYCLES + 1), log_cyc[160] - log_cyc[0]);
		for (int i = 0; i < 160; i++)
			issue(16'hFE00 + 16'(i), 8'h00, 1'b0);
		wait_rsp(160);
		for (int i = 0; i < 160; i++) begin
			got = rsp_q.pop_front();
			assert (got == shadow[{page, 8'(i)}]) else report_mismatch("oam_copy", shadow[{page, 8'(i)}], got);
		end
		read_check("dma_page_reg", 16'hFF46, page);
	endtask

	// ************************************************************************
	// main sequence
	// ************************************************************************

	initial begin
		logic [7:0] b;
		rst_n         = 1'b0;
		req_valid     = 1'b0;
		req           = '0;
		rsp_credit    = 1'b0;
		hold_credits  = 1'b0;
		cyc           = 0;
		run           = 0;
		cs_cycles     = 0;
		rsp_seen      = 0;
		credits_given = 0;
		crd_back      = 0;
		crd_used      = 0;
		lfsr_state    = 32'heff2;
		for (int i = 0; i < 65536; i++) begin // same fill as the memory model.
			b = take_bits(8);
			shadow[i] = b;
		end
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		test_reset();
		test_rom_reads();
		test_ext_ram();
		test_unmapped();
		test_credit_flow();
		test_dma();
		$display("All tests passed");
		$finish;
	end

endmodule
